/* oled_pkg.sv */
`default_nettype none

package oled_pkg;

    // Status word from the memory test engine, 63 bits
    typedef struct packed {
        logic [1:0]  cmd;       // 0 nop, 1 write burst, 2 read short, 3 read burst
        logic [1:0]  cmd_ack;   // Command echoed by the engine
        logic        wr_valid;
        logic        rd_valid;
        logic [15:0] din;       // Next write data
        logic [24:0] addr;      // Word address
        logic [15:0] rd_data;   // Last word read back
    } status_t;

    // 128-bit display layout, one hex digit per nibble
    typedef struct packed {
        logic [1:0]  pad_127;
        logic [1:0]  cmd;          // Bits 125:124
        logic [1:0]  pad_123;
        logic [1:0]  cmd_ack;      // Bits 121:120
        logic [2:0]  pad_119;
        logic        wr_valid;     // Bit 116
        logic [2:0]  pad_115;
        logic        rd_valid;     // Bit 112
        logic [23:0] pad_111;
        logic [23:0] frame_count;  // Bits 87:64
        logic [15:0] din;          // Bits 63:48
        logic [6:0]  pad_47;
        logic [24:0] addr;         // Bits 40:16
        logic [15:0] rd_data;      // Bits 15:0
    } display_fields_t;

    // Written as fields, read back as 32 digits
    typedef union packed {
        display_fields_t  fields;
        logic [31:0][3:0] nibbles;  // Nibble 31 is the leftmost digit
    } display_word_u;

    localparam int OLED_WIDTH     = 96;
    localparam int OLED_HEIGHT    = 64;
    localparam int X_BITS         = 7;
    localparam int Y_BITS         = 6;
    localparam int FONT_W         = 6;   // 5 glyph columns plus a gap
    localparam int FONT_H         = 8;
    localparam int DIGITS_PER_ROW = 16;

    localparam logic [7:0] COLOR_FG = 8'hFF;  // RGB332 white
    localparam logic [7:0] COLOR_BG = 8'h00;

    // Glyph rows top to bottom, bit 4 is the leftmost column
    localparam logic [4:0] FONT_ROM [16][FONT_H] = '{
        '{5'h0E, 5'h11, 5'h13, 5'h15, 5'h19, 5'h11, 5'h0E, 5'h00},  // 0
        '{5'h04, 5'h0C, 5'h04, 5'h04, 5'h04, 5'h04, 5'h0E, 5'h00},  // 1
        '{5'h0E, 5'h11, 5'h01, 5'h02, 5'h04, 5'h08, 5'h1F, 5'h00},  // 2
        '{5'h1F, 5'h02, 5'h04, 5'h02, 5'h01, 5'h11, 5'h0E, 5'h00},  // 3
        '{5'h02, 5'h06, 5'h0A, 5'h12, 5'h1F, 5'h02, 5'h02, 5'h00},  // 4
        '{5'h1F, 5'h10, 5'h1E, 5'h01, 5'h01, 5'h11, 5'h0E, 5'h00},  // 5
        '{5'h06, 5'h08, 5'h10, 5'h1E, 5'h11, 5'h11, 5'h0E, 5'h00},  // 6
        '{5'h1F, 5'h01, 5'h02, 5'h04, 5'h08, 5'h08, 5'h08, 5'h00},  // 7
        '{5'h0E, 5'h11, 5'h11, 5'h0E, 5'h11, 5'h11, 5'h0E, 5'h00},  // 8
        '{5'h0E, 5'h11, 5'h11, 5'h0F, 5'h01, 5'h02, 5'h0C, 5'h00},  // 9
        '{5'h0E, 5'h11, 5'h11, 5'h11, 5'h1F, 5'h11, 5'h11, 5'h00},  // A
        '{5'h1E, 5'h11, 5'h11, 5'h1E, 5'h11, 5'h11, 5'h1E, 5'h00},  // B
        '{5'h0E, 5'h11, 5'h10, 5'h10, 5'h10, 5'h11, 5'h0E, 5'h00},  // C
        '{5'h1C, 5'h12, 5'h11, 5'h11, 5'h11, 5'h12, 5'h1C, 5'h00},  // D
        '{5'h1F, 5'h10, 5'h10, 5'h1E, 5'h10, 5'h10, 5'h1F, 5'h00},  // E
        '{5'h1F, 5'h10, 5'h10, 5'h1E, 5'h10, 5'h10, 5'h10, 5'h00}   // F
    };

    // SSD1331 power-up, 256 colours, mirrored columns
    localparam int INIT_LEN = 16;
    localparam logic [7:0] INIT_CMDS [INIT_LEN] = '{
        8'hAE,         // Display off
        8'hA0, 8'h22,  // Remap, 8-bit colour, x flip
        8'hA1, 8'h00,  // Start line
        8'hA2, 8'h00,  // Vertical offset
        8'hA4,         // Normal display mode
        8'hA8, 8'h3F,  // 64 rows multiplexed
        8'hAD, 8'h8E,  // External Vcc
        8'h87, 8'h0F,  // Full master current
        8'h2E,         // Scrolling off
        8'hAF          // Display on
    };

endpackage

`default_nettype wire

/* status_snapshot.sv */
`timescale 1ns/10ps
`default_nettype none

module status_snapshot
(
    input  wire                   clk_oled,
    input  wire                   rst_n,
    input  logic                  frame_start,  // First pixel of a frame requested
    input  oled_pkg::status_t     status,
    output oled_pkg::display_word_u display
);
    import oled_pkg::*;

    logic [23:0]     frame_count;  // Frames started since reset
    display_fields_t fields_next;

    // Place each status field at its digit position
    always_comb
    begin
        fields_next             = '0;  // Padding digits read as zero
        fields_next.cmd         = status.cmd;
        fields_next.cmd_ack     = status.cmd_ack;
        fields_next.wr_valid    = status.wr_valid;
        fields_next.rd_valid    = status.rd_valid;
        fields_next.frame_count = frame_count;
        fields_next.din         = status.din;
        fields_next.addr        = status.addr;
        fields_next.rd_data     = status.rd_data;
    end

    // Load once per frame so a frame never shows two status values
    always_ff @(posedge clk_oled or negedge rst_n)
    begin
        if (!rst_n)
        begin
            frame_count <= '0;
            display     <= '0;
        end
        else if (frame_start)
        begin
            display.fields <= fields_next;       // Frame N shows count N
            frame_count    <= frame_count + 24'd1;
        end
    end

endmodule

`default_nettype wire

/* hex_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module hex_decoder
(
    input  wire                           clk_oled,
    input  wire                           rst_n,
    input  logic [oled_pkg::X_BITS-1:0]   x,        // 0 to 95
    input  logic [oled_pkg::Y_BITS-1:0]   y,        // 0 to 63
    input  oled_pkg::display_word_u       display,
    output logic [7:0]                    color
);
    import oled_pkg::*;

    logic [3:0] digit_col;   // Digit within the text row
    logic [2:0] pix_col;     // Column inside the glyph cell
    logic [2:0] text_row;
    logic [2:0] glyph_row;
    logic [4:0] nibble_idx;
    logic [3:0] nibble;
    logic [4:0] glyph;       // One font row
    logic       in_text;
    logic       font_bit;

    // Cell coordinates from the pixel position
    assign digit_col = 4'(x / FONT_W);
    assign pix_col   = 3'(x % FONT_W);
    assign text_row  = 3'(y / FONT_H);
    assign glyph_row = 3'(y % FONT_H);

    // Row 0 holds digits 31..16, row 1 digits 15..0
    assign in_text = (text_row < 3'd2);

    always_comb
    begin
        if (text_row == 3'd0)
        begin
            nibble_idx = 5'(2 * DIGITS_PER_ROW - 1 - int'(digit_col));
        end
        else
        begin
            nibble_idx = 5'(DIGITS_PER_ROW - 1 - int'(digit_col));
        end
    end

    assign nibble = display.nibbles[nibble_idx];
    assign glyph  = FONT_ROM[nibble][glyph_row];

    // Last cell column is the gap between digits
    assign font_bit = (pix_col < 3'(FONT_W - 1)) ? glyph[3'(FONT_W - 2) - pix_col] : 1'b0;

    // One cycle behind x and y
    always_ff @(posedge clk_oled or negedge rst_n)
    begin
        if (!rst_n)
        begin
            color <= COLOR_BG;
        end
        else
        begin
            color <= (in_text && font_bit) ? COLOR_FG : COLOR_BG;  // Rows 2..7 stay dark
        end
    end

endmodule

`default_nettype wire

/* oled_video.sv */
`timescale 1ns/10ps
`default_nettype none

module oled_video
(
    input  wire                           clk_oled,
    input  wire                           rst_n,
    input  logic [7:0]                    color,        // Colour of pixel x,y
    output logic [oled_pkg::X_BITS-1:0]   x,
    output logic [oled_pkg::Y_BITS-1:0]   y,
    output logic                          next_pixel,   // Pixel x,y taken
    output logic                          frame_start,  // Frame begins at (0,0)
    output logic                          oled_csn,
    output logic                          oled_clk,
    output logic                          oled_mosi,
    output logic                          oled_dc,      // Low for commands
    output logic                          oled_resn
);
    import oled_pkg::*;

    enum logic [1:0] {ST_RESET, ST_INIT, ST_PIXEL} state;

    logic [3:0] tick;       // Bit index in [3:1], clock phase in [0]
    logic [3:0] init_idx;   // Command byte being sent
    logic [7:0] shift_reg;  // MSB on the wire
    logic       byte_end;
    logic       last_init;
    logic       last_x;
    logic       last_y;

    assign byte_end  = (tick == 4'hF);
    assign last_init = (init_idx == 4'(INIT_LEN - 1));
    assign last_x    = (x == X_BITS'(OLED_WIDTH - 1));
    assign last_y    = (y == Y_BITS'(OLED_HEIGHT - 1));

    // Pixel byte loads at the end of the last command and of every pixel
    assign next_pixel = byte_end && ((state == ST_PIXEL) || (state == ST_INIT && last_init));

    // Sequencer, 16 cycles per phase step
    always_ff @(posedge clk_oled or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state    <= ST_RESET;
            tick     <= '0;
            init_idx <= '0;
        end
        else
        begin
            tick <= tick + 4'd1;  // Wraps once per byte
            if (byte_end)
            begin
                case (state)
                    ST_RESET: state <= ST_INIT;      // Reset hold over
                    ST_INIT:
                    begin
                        if (last_init)
                        begin
                            state <= ST_PIXEL;
                        end
                        else
                        begin
                            init_idx <= init_idx + 4'd1;
                        end
                    end
                    default: state <= ST_PIXEL;      // Stream forever
                endcase
            end
        end
    end

    // Byte serializer
    always_ff @(posedge clk_oled or negedge rst_n)
    begin
        if (!rst_n)
        begin
            shift_reg <= '0;
        end
        else if (byte_end)
        begin
            if (state == ST_RESET)
            begin
                shift_reg <= INIT_CMDS[0];
            end
            else if (next_pixel)
            begin
                shift_reg <= color;  // Settled long before this edge
            end
            else
            begin
                shift_reg <= INIT_CMDS[init_idx + 4'd1];
            end
        end
        else if (tick[0] && state != ST_RESET)
        begin
            shift_reg <= {shift_reg[6:0], 1'b0};  // After the rising edge
        end
    end

    // Pixel walker, x first then y
    always_ff @(posedge clk_oled or negedge rst_n)
    begin
        if (!rst_n)
        begin
            x           <= '0;
            y           <= '0;
            frame_start <= 1'b0;
        end
        else
        begin
            // First frame when init starts, later ones on wrap
            frame_start <= (state == ST_RESET && byte_end) || (next_pixel && last_x && last_y);
            if (next_pixel)
            begin
                x <= last_x ? '0 : x + 1'b1;
                if (last_x)
                begin
                    y <= last_y ? '0 : y + 1'b1;
                end
            end
        end
    end

    assign oled_resn = (state != ST_RESET);
    assign oled_csn  = (state == ST_RESET);            // Low from first command on
    assign oled_clk  = (state != ST_RESET) && tick[0];  // Low then high per bit
    assign oled_dc   = (state == ST_PIXEL);
    assign oled_mosi = shift_reg[7];

endmodule

`default_nettype wire

/* oled_status_top.sv */
`timescale 1ns/10ps
`default_nettype none

module oled_status_top
(
    input  wire               clk_oled,
    input  wire               rst_n,
    input  oled_pkg::status_t status,     // From the memory test engine
    output logic              oled_csn,
    output logic              oled_clk,
    output logic              oled_mosi,
    output logic              oled_dc,
    output logic              oled_resn
);
    import oled_pkg::*;

    logic [X_BITS-1:0] x;
    logic [Y_BITS-1:0] y;
    logic              frame_start;  // Snapshot strobe
    logic [7:0]        color;
    display_word_u     display;      // Frozen for one frame

    status_snapshot u_snapshot
    (
        .clk_oled    (clk_oled),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .status      (status),
        .display     (display)
    );

    hex_decoder u_decoder
    (
        .clk_oled (clk_oled),
        .rst_n    (rst_n),
        .x        (x),
        .y        (y),
        .display  (display),
        .color    (color)
    );

    oled_video u_video
    (
        .clk_oled    (clk_oled),
        .rst_n       (rst_n),
        .color       (color),
        .x           (x),
        .y           (y),
        .next_pixel  (),             // Decoder follows x and y directly
        .frame_start (frame_start),
        .oled_csn    (oled_csn),
        .oled_clk    (oled_clk),
        .oled_mosi   (oled_mosi),
        .oled_dc     (oled_dc),
        .oled_resn   (oled_resn)
    );

endmodule

`default_nettype wire

/* oled_spi_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module oled_spi_checker
(
    input  wire                           clk_oled,
    input  wire                           rst_n,
    input  logic [oled_pkg::X_BITS-1:0]   x,
    input  logic [oled_pkg::Y_BITS-1:0]   y,
    input  logic                          next_pixel,
    input  logic                          frame_start,
    input  logic                          oled_csn,
    input  logic                          oled_clk,
    input  logic                          oled_dc
);
    import oled_pkg::*;

    int cmd_bits;  // Serial clock pulses sent as commands

    always_ff @(posedge clk_oled or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cmd_bits <= 0;
        end
        else if (oled_clk && !oled_dc)
        begin
            cmd_bits <= cmd_bits + 1;  // One high cycle per bit
        end
    end

    // Serial clock idle while deselected
    clk_needs_cs: assert property (@(posedge clk_oled) disable iff (!rst_n)
        $changed(oled_clk) |-> !oled_csn)
        else $error("oled_clk changed while oled_csn was high");

    // Data mode only after all command bits
    dc_after_init: assert property (@(posedge clk_oled) disable iff (!rst_n)
        $rose(oled_dc) |-> (cmd_bits == 8 * INIT_LEN))
        else $error("oled_dc rose before the last init byte was sent");

    dc_stays_high: assert property (@(posedge clk_oled) disable iff (!rst_n)
        oled_dc |=> oled_dc)
        else $error("oled_dc fell during pixel streaming");

    pixel_strobe_short: assert property (@(posedge clk_oled) disable iff (!rst_n)
        next_pixel |=> !next_pixel)
        else $error("next_pixel held high for more than one cycle");

    frame_at_origin: assert property (@(posedge clk_oled) disable iff (!rst_n)
        frame_start |-> (x == '0 && y == '0))
        else $error("frame_start pulsed away from pixel (0,0)");

endmodule

bind oled_video oled_spi_checker u_spi_checker
(
    .clk_oled    (clk_oled),
    .rst_n       (rst_n),
    .x           (x),
    .y           (y),
    .next_pixel  (next_pixel),
    .frame_start (frame_start),
    .oled_csn    (oled_csn),
    .oled_clk    (oled_clk),
    .oled_dc     (oled_dc)
);

`default_nettype wire

/* tb_oled_status.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_oled_status;
    import oled_pkg::*;

    localparam int NUM_LINES    = 6;                        // Lines in the data file
    localparam int NUM_FRAMES   = NUM_LINES + 1;            // Last line held one more frame
    localparam int FRAME_PIXELS = OLED_WIDTH * OLED_HEIGHT;
    localparam int TOTAL_BYTES  = INIT_LEN + NUM_FRAMES * FRAME_PIXELS;
    localparam int RESET_CYCLES = 16;
    localparam int RESN_HOLD    = 16;                       // Panel reset low after rst_n
    localparam int CYCLE_LIMIT  = RESET_CYCLES + RESN_HOLD + INIT_LEN * 16
                                  + (NUM_FRAMES + 1) * FRAME_PIXELS * 16;

    logic        clk_oled;
    logic        rst_n;
    status_t     status;
    logic        oled_csn;
    logic        oled_clk;
    logic        oled_mosi;
    logic        oled_dc;
    logic        oled_resn;
    logic [24:0] stim [NUM_LINES * 7];  // Seven fields per line
    logic [7:0]  rx_byte;               // Bits gathered from the panel port
    int          rx_bits;
    int          byte_count;
    int          mismatch_count;
    int          other_count;
    int          cycle_count;

    oled_status_top UUT
    (
        .clk_oled  (clk_oled),
        .rst_n     (rst_n),
        .status    (status),
        .oled_csn  (oled_csn),
        .oled_clk  (oled_clk),
        .oled_mosi (oled_mosi),
        .oled_dc   (oled_dc),
        .oled_resn (oled_resn)
    );

    always #5 clk_oled = ~clk_oled;

    function automatic status_t line_status(input int k);
        status_t s;
        s.cmd      = stim[7 * k][1:0];
        s.cmd_ack  = stim[7 * k + 1][1:0];
        s.wr_valid = stim[7 * k + 2][0];
        s.rd_valid = stim[7 * k + 3][0];
        s.din      = stim[7 * k + 4][15:0];
        s.addr     = stim[7 * k + 5];
        s.rd_data  = stim[7 * k + 6][15:0];
        return s;
    endfunction

    // Pixel colour from the digit layout and the font
    function automatic logic [7:0] expected_pixel(input status_t s, input int frame,
                                                  input int px, input int py);
        logic [127:0] word;
        logic [23:0]  fc;
        logic [3:0]   nib;
        logic [4:0]   glyph;
        int           row;
        int           col;
        int           pc;
        int           idx;
        fc   = 24'(frame);
        word = {2'b00, s.cmd, 2'b00, s.cmd_ack, 3'b000, s.wr_valid, 3'b000, s.rd_valid,
                24'h0, fc, s.din, 7'h00, s.addr, s.rd_data};
        row  = py / FONT_H;
        col  = px / FONT_W;
        pc   = px % FONT_W;
        if (row > 1 || pc == FONT_W - 1)
        begin
            return COLOR_BG;  // Lower rows and glyph gap
        end
        idx   = (row == 0) ? 31 - col : 15 - col;
        nib   = word[idx * 4 +: 4];
        glyph = FONT_ROM[nib][py % FONT_H];
        return glyph[4 - pc] ? COLOR_FG : COLOR_BG;
    endfunction

    task automatic check_byte(input logic [7:0] got, input logic dc);
        int         pix;
        int         frame;
        logic [7:0] exp;
        status_t    s;
        assert (!oled_csn) else
        begin
            other_count++;
            $display("%0t: oled_csn was high while byte %0d was clocked in", $time, byte_count);
        end
        if (byte_count < INIT_LEN)
        begin
            assert (dc == 1'b0) else
            begin
                other_count++;
                $display("%0t: command byte %0d was sent with oled_dc high", $time, byte_count);
            end
            assert (got == INIT_CMDS[byte_count]) else
            begin
                mismatch_count++;
                $display("mismatch at %0t: oled_mosi init byte %0d got %h expected %h",
                         $time, byte_count, got, INIT_CMDS[byte_count]);
            end
        end
        else
        begin
            pix   = (byte_count - INIT_LEN) % FRAME_PIXELS;
            frame = (byte_count - INIT_LEN) / FRAME_PIXELS;
            s     = line_status((frame < NUM_LINES) ? frame : NUM_LINES - 1);
            exp   = expected_pixel(s, frame, pix % OLED_WIDTH, pix / OLED_WIDTH);
            assert (dc == 1'b1) else
            begin
                other_count++;
                $display("%0t: pixel byte %0d of frame %0d was sent as a command",
                         $time, pix, frame);
            end
            assert (got == exp) else
            begin
                mismatch_count++;
                $display("mismatch at %0t: oled_mosi frame %0d x %0d y %0d got %h expected %h",
                         $time, frame, pix % OLED_WIDTH, pix / OLED_WIDTH, got, exp);
            end
            // This frame is captured, next line goes in for the next one
            if (pix == 0 && frame + 1 < NUM_LINES)
            begin
                #1;
                status = line_status(frame + 1);
            end
        end
        byte_count++;
    endtask

    // Panel samples on the rising serial clock
    always @(posedge oled_clk)
    begin
        rx_byte = {rx_byte[6:0], oled_mosi};
        rx_bits++;
        if (rx_bits == 8)
        begin
            rx_bits = 0;
            check_byte(rx_byte, oled_dc);
        end
    end

    always @(posedge clk_oled)
    begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("timeout: stopped after %0d cycles with %0d of %0d bytes received",
                     cycle_count, byte_count, TOTAL_BYTES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial
    begin
        clk_oled       = 1'b0;
        rst_n          = 1'b0;
        status         = '0;
        rx_byte        = '0;
        rx_bits        = 0;
        byte_count     = 0;
        mismatch_count = 0;
        other_count    = 0;
        cycle_count    = 0;
        $readmemh("display_input.mem", stim);
        status = line_status(0);  // Frame 0 is captured as init starts
        repeat (RESET_CYCLES) @(posedge clk_oled);
        #1 rst_n = 1'b1;
        assert (oled_resn == 1'b0 && oled_csn == 1'b1) else
        begin
            other_count++;
            $display("%0t: panel not in reset with chip select idle after reset", $time);
        end
        // Panel reset spans exactly the hold time
        repeat (RESN_HOLD - 1) @(posedge clk_oled);
        #1;
        assert (oled_resn == 1'b0 && oled_csn == 1'b1) else
        begin
            other_count++;
            $display("%0t: panel reset ended before the hold time was over", $time);
        end
        @(posedge clk_oled);
        #1;
        assert (oled_resn == 1'b1 && oled_csn == 1'b0) else
        begin
            other_count++;
            $display("%0t: panel still in reset or deselected after the hold time", $time);
        end
        wait (byte_count >= TOTAL_BYTES);
        $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
        if (mismatch_count + other_count == 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* display_input.mem */
// Columns: cmd cmd_ack wr_valid rd_valid din addr rd_data, one test frame per line
// addr is 25 bits, so up to 1FFFFFF
0 0 0 0 0000 0000000 0000
1 1 1 0 A5C3 1234567 0000
2 1 0 1 FFFF 1FFFFFF BEEF
3 3 1 1 0F1E 1000000 2D3C
2 2 0 1 89AB 0ABCDEF 4B5A
1 0 1 0 7654 0FEDCBA 6978

/* flist.f */
oled_pkg.sv
status_snapshot.sv
hex_decoder.sv
oled_video.sv
oled_status_top.sv
oled_spi_checker.sv
tb_oled_status.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = tb_oled_status
FLIST = flist.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "FAIL: see errors above" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
